// ==== src/geom_pkg.sv ====
package geom_pkg;

	// all motion math runs in 1/64 pixel units, so divide by 64 to get pixels
	localparam int fixed_point_mult = 64;

	// visible frame extent, last pixel index on each axis
	localparam int frame_width_fp  = 639 * fixed_point_mult;
	localparam int frame_height_fp = 479 * fixed_point_mult;

	localparam int tile_size_fp  = 64 * fixed_point_mult;
	localparam int bumpy_size_fp = 16 * fixed_point_mult; // square sprite box

	// character starts centered inside the first tile
	localparam int start_x_fp = tile_size_fp / 2 - bumpy_size_fp / 2;
	localparam int start_y_fp = tile_size_fp / 2 - bumpy_size_fp / 2;

	// margin kept from the side walls before a wall counts as hit
	localparam int border_offset = 100;

	// top-left corner in whole pixels
	typedef struct packed {
		logic signed [10:0] x;
		logic signed [10:0] y;
	} pixel_pos_t;

	// top-left corner in sub-pixel units
	typedef struct packed {
		logic signed [31:0] x;
		logic signed [31:0] y;
	} fp_pos_t;

endpackage

// ==== src/bumpy_pkg.sv ====
package bumpy_pkg;

	// motion states of the character
	typedef enum logic [3:0] {
		s_reset,
		s_idle,
		s_left,
		s_right,
		s_down,
		s_up,
		s_die,
		s_bounce_from_left,
		s_bounce_from_right,
		s_bounce_from_top,
		s_down_from_right,
		s_down_from_left
	} motion_state_t;

	// one-hot border codes
	typedef enum logic [3:0] {
		edge_none   = 4'b0000,
		edge_bottom = 4'b0001,
		edge_right  = 4'b0010,
		edge_top    = 4'b0100,
		edge_left   = 4'b1000
	} edge_code_t;

	// direction keys, level inputs
	typedef struct packed {
		logic left;
		logic right;
		logic up;
		logic down;
	} keys_t;

	typedef struct packed {
		logic       collision;
		edge_code_t code;
	} hit_t;

	// speeds in sub-pixel units per frame
	localparam int speed_x = 60;
	localparam int speed_y = 2 * speed_x;

	// jump height is one tile minus a step
	localparam int step_size_fp = 7 * geom_pkg::fixed_point_mult;
	localparam int jump_limit   = geom_pkg::tile_size_fp - step_size_fp;

endpackage

// ==== src/frame_edge_detect.sv ====
`timescale 1ns/1ps

module frame_edge_detect (
	input  logic              clk,
	input  logic              resetN,
	input  geom_pkg::fp_pos_t pos_fp,
	output bumpy_pkg::hit_t   hit
);

	bumpy_pkg::edge_code_t edge_code;
	logic signed [31:0]    box_right;
	logic signed [31:0]    box_bottom;

	// far corner of the character box
	assign box_right  = pos_fp.x + geom_pkg::bumpy_size_fp;
	assign box_bottom = pos_fp.y + geom_pkg::bumpy_size_fp;

	// only one edge is reported, floor wins over ceiling over walls
	always_comb begin
		edge_code = bumpy_pkg::edge_none;
		if (box_bottom >= geom_pkg::frame_height_fp) begin
			edge_code = bumpy_pkg::edge_bottom;
		end
		else if (pos_fp.y <= 0) begin
			edge_code = bumpy_pkg::edge_top;
		end
		else if (pos_fp.x < geom_pkg::border_offset) begin
			edge_code = bumpy_pkg::edge_left;
		end
		else if (box_right > (geom_pkg::frame_width_fp - geom_pkg::border_offset)) begin
			edge_code = bumpy_pkg::edge_right;
		end
	end

	// registered so fsm and motion block see the same value all cycle
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			hit.collision <= 1'b0;
			hit.code      <= bumpy_pkg::edge_none;
		end
		else begin
			hit.collision <= (edge_code != bumpy_pkg::edge_none);
			hit.code      <= edge_code;
		end
	end

endmodule

// ==== src/bumpy_fsm.sv ====
`timescale 1ns/1ps

module bumpy_fsm (
	input  logic                     clk,
	input  logic                     resetN,
	input  bumpy_pkg::keys_t         keys,
	input  logic                     hazard,
	input  bumpy_pkg::hit_t          hit,
	output bumpy_pkg::motion_state_t state
);

	bumpy_pkg::motion_state_t next_state;
	bumpy_pkg::motion_state_t key_state;
	logic hit_bottom;
	logic hit_top;
	logic hit_left;
	logic hit_right;

	assign hit_bottom = hit.collision && (hit.code == bumpy_pkg::edge_bottom);
	assign hit_top    = hit.collision && (hit.code == bumpy_pkg::edge_top);
	assign hit_left   = hit.collision && (hit.code == bumpy_pkg::edge_left);
	assign hit_right  = hit.collision && (hit.code == bumpy_pkg::edge_right);

	// key decode, left > right > up > down
	always_comb begin
		if (keys.left)
			key_state = bumpy_pkg::s_left;
		else if (keys.right)
			key_state = bumpy_pkg::s_right;
		else if (keys.up)
			key_state = bumpy_pkg::s_up;
		else if (keys.down)
			key_state = bumpy_pkg::s_down;
		else
			key_state = bumpy_pkg::s_idle;
	end

	always_comb begin
		next_state = state;
		case (state)
			bumpy_pkg::s_reset:
				next_state = bumpy_pkg::s_idle;
			bumpy_pkg::s_die:
				next_state = bumpy_pkg::s_die; // only reset leaves
			bumpy_pkg::s_idle, bumpy_pkg::s_left, bumpy_pkg::s_right,
			bumpy_pkg::s_up, bumpy_pkg::s_down: begin
				// a wall hit in the direction of motion beats the keys
				if ((state == bumpy_pkg::s_left) && hit_left)
					next_state = bumpy_pkg::s_bounce_from_left;
				else if ((state == bumpy_pkg::s_right) && hit_right)
					next_state = bumpy_pkg::s_bounce_from_right;
				else if ((state == bumpy_pkg::s_up) && hit_top)
					next_state = bumpy_pkg::s_bounce_from_top;
				else
					next_state = key_state;
			end
			bumpy_pkg::s_bounce_from_left: begin
				if (hit_bottom)
					next_state = bumpy_pkg::s_idle;
				else if (keys.down)
					next_state = bumpy_pkg::s_down_from_left;
			end
			bumpy_pkg::s_bounce_from_right: begin
				if (hit_bottom)
					next_state = bumpy_pkg::s_idle;
				else if (keys.down)
					next_state = bumpy_pkg::s_down_from_right;
			end
			bumpy_pkg::s_bounce_from_top, bumpy_pkg::s_down_from_left,
			bumpy_pkg::s_down_from_right: begin
				if (hit_bottom)
					next_state = bumpy_pkg::s_idle; // landed
			end
			default:
				next_state = bumpy_pkg::s_idle;
		endcase

		// hazard kills the character from anywhere after reset has settled
		if (hazard && (state != bumpy_pkg::s_reset))
			next_state = bumpy_pkg::s_die;
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			state <= bumpy_pkg::s_reset;
		else
			state <= next_state;
	end

endmodule

// ==== src/bumpy_move.sv ====
`timescale 1ns/1ps

module bumpy_move (
	input  logic                     clk,
	input  logic                     resetN,
	input  logic                     start_of_frame, // one pulse per frame
	input  bumpy_pkg::motion_state_t state,
	input  bumpy_pkg::hit_t          hit,
	output geom_pkg::fp_pos_t        pos_fp,
	output geom_pkg::pixel_pos_t     pos,
	output logic                     dead_led
);

	logic signed [31:0] vel_x;
	logic signed [31:0] vel_y;
	logic signed [31:0] jump_start_x;
	logic signed [31:0] jump_start_y;
	logic signed [31:0] pix_x;
	logic signed [31:0] pix_y;
	logic               hit_bottom;
	logic               hit_top;
	logic               above_jump; // risen past the jump height

	assign hit_bottom = hit.collision && (hit.code == bumpy_pkg::edge_bottom);
	assign hit_top    = hit.collision && (hit.code == bumpy_pkg::edge_top);
	assign above_jump = (pos_fp.y < (jump_start_y - bumpy_pkg::jump_limit)) && (vel_y <= 0);

	// remember where the last floor contact was
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			jump_start_x <= '0;
			jump_start_y <= '0;
		end
		else if (hit_bottom) begin
			jump_start_x <= pos_fp.x;
			jump_start_y <= pos_fp.y;
		end
	end

	// vertical speed
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			vel_y <= '0;
		end
		else begin
			case (state)
				bumpy_pkg::s_reset:
					vel_y <= '0;
				bumpy_pkg::s_idle, bumpy_pkg::s_left, bumpy_pkg::s_right,
				bumpy_pkg::s_bounce_from_left, bumpy_pkg::s_bounce_from_right: begin
					if (vel_y == 0)
						vel_y <= bumpy_pkg::speed_y; // start falling
					else if (hit_bottom && (vel_y >= 0))
						vel_y <= -bumpy_pkg::speed_y; // bounce off the floor
					else if (above_jump)
						vel_y <= bumpy_pkg::speed_y;
				end
				bumpy_pkg::s_down:
					vel_y <= bumpy_pkg::speed_y;
				bumpy_pkg::s_up:
					vel_y <= -bumpy_pkg::speed_y;
				bumpy_pkg::s_bounce_from_top: begin
					if (hit_top && (vel_y <= 0))
						vel_y <= bumpy_pkg::speed_y;
					else
						vel_y <= -bumpy_pkg::speed_y;
				end
				bumpy_pkg::s_down_from_left, bumpy_pkg::s_down_from_right: begin
					if (above_jump)
						vel_y <= bumpy_pkg::speed_y;
				end
				default: ; // s_die keeps its vertical speed
			endcase
		end
	end

	// horizontal speed
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			vel_x <= '0;
		end
		else begin
			case (state)
				bumpy_pkg::s_left:
					vel_x <= -bumpy_pkg::speed_x;
				bumpy_pkg::s_right:
					vel_x <= bumpy_pkg::speed_x;
				bumpy_pkg::s_bounce_from_left: begin
					// push away once inside the wall margin
					if ((pos_fp.x < geom_pkg::border_offset) && (vel_x <= 0))
						vel_x <= bumpy_pkg::speed_x;
					else
						vel_x <= -bumpy_pkg::speed_x;
				end
				bumpy_pkg::s_bounce_from_right: begin
					if (((pos_fp.x + geom_pkg::bumpy_size_fp) >
						(geom_pkg::frame_width_fp - geom_pkg::border_offset)) && (vel_x >= 0))
						vel_x <= -bumpy_pkg::speed_x;
					else
						vel_x <= bumpy_pkg::speed_x;
				end
				bumpy_pkg::s_down_from_left: begin
					if ((pos_fp.x < (jump_start_x - bumpy_pkg::jump_limit)) && (vel_x <= 0))
						vel_x <= '0; // drift has gone far enough
				end
				bumpy_pkg::s_down_from_right: begin
					if ((pos_fp.x > (jump_start_x + bumpy_pkg::jump_limit)) && (vel_x >= 0))
						vel_x <= '0;
				end
				default:
					vel_x <= '0; // reset, idle, up, down, top bounce, die
			endcase
		end
	end

	// dead indicator, lit by the hazard and cleared by a down move
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			dead_led <= 1'b0;
		else if (state == bumpy_pkg::s_die)
			dead_led <= 1'b1;
		else if (state == bumpy_pkg::s_down)
			dead_led <= 1'b0;
	end

	// position integral, once per frame
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			pos_fp.x <= geom_pkg::start_x_fp;
			pos_fp.y <= geom_pkg::start_y_fp;
		end
		else if (start_of_frame) begin
			pos_fp.x <= pos_fp.x + vel_x;
			pos_fp.y <= pos_fp.y + vel_y;
		end
	end

	// signed divide rounds toward zero
	assign pix_x = pos_fp.x / geom_pkg::fixed_point_mult;
	assign pix_y = pos_fp.y / geom_pkg::fixed_point_mult;
	assign pos.x = pix_x[10:0];
	assign pos.y = pix_y[10:0];

endmodule

// ==== src/bumpy_top.sv ====
`timescale 1ns/1ps

module bumpy_top (
	input  logic                 clk,
	input  logic                 resetN,
	input  logic                 start_of_frame,
	input  bumpy_pkg::keys_t     keys,
	input  logic                 hazard,
	output geom_pkg::pixel_pos_t pos,
	output logic                 dead_led
);

	bumpy_pkg::motion_state_t state;
	bumpy_pkg::hit_t          hit;      // registered border hit
	geom_pkg::fp_pos_t        pos_fp;   // sub-pixel position

	bumpy_fsm u_fsm (
		.clk    (clk),
		.resetN (resetN),
		.keys   (keys),
		.hazard (hazard),
		.hit    (hit),
		.state  (state)
	);

	bumpy_move u_move (
		.clk            (clk),
		.resetN         (resetN),
		.start_of_frame (start_of_frame),
		.state          (state),
		.hit            (hit),
		.pos_fp         (pos_fp),
		.pos            (pos),
		.dead_led       (dead_led)
	);

	frame_edge_detect u_edge (
		.clk    (clk),
		.resetN (resetN),
		.pos_fp (pos_fp),
		.hit    (hit)
	);

endmodule

// ==== tests/bumpy_model.svh ====
`ifndef BUMPY_MODEL_SVH
`define BUMPY_MODEL_SVH

// cycle-level reference of the controller, the motion rules and the border rules
bumpy_pkg::motion_state_t m_state;
bumpy_pkg::edge_code_t    m_edge;      // border code as seen one clock late
int                       m_x;
int                       m_y;
int                       m_vx;
int                       m_vy;
int                       m_jump_x;    // last floor contact
int                       m_jump_y;
logic                     m_dead;

// first matching border wins, floor then ceiling then walls
function automatic bumpy_pkg::edge_code_t border_of(input int x, input int y);
	if (y + geom_pkg::bumpy_size_fp >= geom_pkg::frame_height_fp)
		return bumpy_pkg::edge_bottom;
	if (y <= 0)
		return bumpy_pkg::edge_top;
	if (x < geom_pkg::border_offset)
		return bumpy_pkg::edge_left;
	if (x + geom_pkg::bumpy_size_fp > geom_pkg::frame_width_fp - geom_pkg::border_offset)
		return bumpy_pkg::edge_right;
	return bumpy_pkg::edge_none;
endfunction

function automatic bumpy_pkg::motion_state_t keys_to_state(input bumpy_pkg::keys_t k);
	if (k.left)
		return bumpy_pkg::s_left;
	if (k.right)
		return bumpy_pkg::s_right;
	if (k.up)
		return bumpy_pkg::s_up;
	if (k.down)
		return bumpy_pkg::s_down;
	return bumpy_pkg::s_idle;
endfunction

function automatic bumpy_pkg::motion_state_t next_motion(input bumpy_pkg::motion_state_t s,
		input bumpy_pkg::keys_t k, input logic hz, input bumpy_pkg::edge_code_t e);
	bumpy_pkg::motion_state_t ns;
	ns = s;
	case (s)
		bumpy_pkg::s_reset: ns = bumpy_pkg::s_idle;
		bumpy_pkg::s_die:   ns = bumpy_pkg::s_die;
		bumpy_pkg::s_idle, bumpy_pkg::s_down, bumpy_pkg::s_left, bumpy_pkg::s_right,
		bumpy_pkg::s_up: begin
			if (s == bumpy_pkg::s_left && e == bumpy_pkg::edge_left)
				ns = bumpy_pkg::s_bounce_from_left;
			else if (s == bumpy_pkg::s_right && e == bumpy_pkg::edge_right)
				ns = bumpy_pkg::s_bounce_from_right;
			else if (s == bumpy_pkg::s_up && e == bumpy_pkg::edge_top)
				ns = bumpy_pkg::s_bounce_from_top;
			else
				ns = keys_to_state(k);
		end
		bumpy_pkg::s_bounce_from_left, bumpy_pkg::s_bounce_from_right: begin
			if (e == bumpy_pkg::edge_bottom)
				ns = bumpy_pkg::s_idle;
			else if (k.down)
				ns = (s == bumpy_pkg::s_bounce_from_left) ? bumpy_pkg::s_down_from_left
					: bumpy_pkg::s_down_from_right;
		end
		default: if (e == bumpy_pkg::edge_bottom) ns = bumpy_pkg::s_idle; // top bounce, down-from
	endcase
	if (hz && s != bumpy_pkg::s_reset)
		ns = bumpy_pkg::s_die;
	return ns;
endfunction

function automatic int next_vy(input bumpy_pkg::motion_state_t s,
		input bumpy_pkg::edge_code_t e, input int vy, input int y, input int jy);
	logic past_peak;
	past_peak = (y < jy - bumpy_pkg::jump_limit) && (vy <= 0);
	case (s)
		bumpy_pkg::s_reset: return 0;
		bumpy_pkg::s_down:  return bumpy_pkg::speed_y;
		bumpy_pkg::s_up:    return -bumpy_pkg::speed_y;
		bumpy_pkg::s_idle, bumpy_pkg::s_left, bumpy_pkg::s_right,
		bumpy_pkg::s_bounce_from_left, bumpy_pkg::s_bounce_from_right: begin
			if (vy == 0)
				return bumpy_pkg::speed_y; // gravity from rest
			if (e == bumpy_pkg::edge_bottom && vy >= 0)
				return -bumpy_pkg::speed_y;
			return past_peak ? bumpy_pkg::speed_y : vy;
		end
		bumpy_pkg::s_bounce_from_top:
			return (e == bumpy_pkg::edge_top && vy <= 0) ? bumpy_pkg::speed_y
				: -bumpy_pkg::speed_y;
		bumpy_pkg::s_down_from_left, bumpy_pkg::s_down_from_right:
			return past_peak ? bumpy_pkg::speed_y : vy;
		default: return vy;
	endcase
endfunction

function automatic int next_vx(input bumpy_pkg::motion_state_t s, input int vx,
		input int x, input int jx);
	int right_limit;
	right_limit = geom_pkg::frame_width_fp - geom_pkg::border_offset;
	case (s)
		bumpy_pkg::s_left:  return -bumpy_pkg::speed_x;
		bumpy_pkg::s_right: return bumpy_pkg::speed_x;
		bumpy_pkg::s_bounce_from_left:
			return (x < geom_pkg::border_offset && vx <= 0) ? bumpy_pkg::speed_x
				: -bumpy_pkg::speed_x;
		bumpy_pkg::s_bounce_from_right:
			return (x + geom_pkg::bumpy_size_fp > right_limit && vx >= 0)
				? -bumpy_pkg::speed_x : bumpy_pkg::speed_x;
		bumpy_pkg::s_down_from_left:
			return (x < jx - bumpy_pkg::jump_limit && vx <= 0) ? 0 : vx;
		bumpy_pkg::s_down_from_right:
			return (x > jx + bumpy_pkg::jump_limit && vx >= 0) ? 0 : vx;
		default: return 0;
	endcase
endfunction

task automatic model_reset();
	m_state  = bumpy_pkg::s_reset;
	m_edge   = bumpy_pkg::edge_none;
	m_x      = geom_pkg::start_x_fp;
	m_y      = geom_pkg::start_y_fp;
	m_vx     = 0;
	m_vy     = 0;
	m_jump_x = 0;
	m_jump_y = 0;
	m_dead   = 1'b0;
endtask

// one clock edge, every next value comes from the old ones
task automatic model_step(input bumpy_pkg::keys_t k, input logic hz, input logic sof);
	bumpy_pkg::motion_state_t ns;
	bumpy_pkg::edge_code_t    ne;
	int                       nvx;
	int                       nvy;
	ns  = next_motion(m_state, k, hz, m_edge);
	ne  = border_of(m_x, m_y);
	nvx = next_vx(m_state, m_vx, m_x, m_jump_x);
	nvy = next_vy(m_state, m_edge, m_vy, m_y, m_jump_y);
	if (m_state == bumpy_pkg::s_die)
		m_dead = 1'b1;
	else if (m_state == bumpy_pkg::s_down)
		m_dead = 1'b0;
	if (m_edge == bumpy_pkg::edge_bottom) begin
		m_jump_x = m_x;
		m_jump_y = m_y;
	end
	if (sof) begin
		m_x = m_x + m_vx;
		m_y = m_y + m_vy;
	end
	m_state = ns;
	m_edge  = ne;
	m_vx    = nvx;
	m_vy    = nvy;
endtask

`endif

// ==== tests/bumpy_tb.sv ====
`timescale 1ns/1ps

module bumpy_tb;

	localparam int clk_period     = 100;
	localparam int frame_cycles   = 8;
	localparam int n_frames       = 3000;
	localparam int timeout_cycles = n_frames * frame_cycles + 20;

	logic                 clk;
	logic                 resetN;
	logic                 start_of_frame;
	bumpy_pkg::keys_t     keys;
	logic                 hazard;
	geom_pkg::pixel_pos_t pos;
	logic                 dead_led;

	logic [31:0] rng;
	int          hold;         // frames left for the current key pattern
	int          after_death;  // frames until the restart, 0 when alive
	logic        hit_hazard;

	`include "bumpy_model.svh"

	bumpy_top u_dut (
		.clk            (clk),
		.resetN         (resetN),
		.start_of_frame (start_of_frame),
		.keys           (keys),
		.hazard         (hazard),
		.pos            (pos),
		.dead_led       (dead_led)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// model follows the same edges, inputs are stable there
	always @(posedge clk or negedge resetN) begin
		if (!resetN)
			model_reset();
		else
			model_step(keys, hazard, start_of_frame);
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] v;
		v = s;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	// mostly single keys so walls and ceiling are reached
	function automatic bumpy_pkg::keys_t pick_keys(input logic [31:0] r);
		bumpy_pkg::keys_t k;
		k = '0;
		case (r % 8)
			1: k.left  = 1'b1;
			2: k.right = 1'b1;
			3: k.up    = 1'b1;
			4: k.down  = 1'b1;
			5: begin
				k.left = 1'b1;
				k.down = 1'b1;
			end
			6: k = r[11:8];
			default: k = '0;
		endcase
		return k;
	endfunction

	function automatic logic signed [10:0] to_pixel(input int v);
		int p;
		p = v / geom_pkg::fixed_point_mult; // rounds toward zero
		return p[10:0];
	endfunction

	task automatic check_outputs();
		logic signed [10:0] ex;
		logic signed [10:0] ey;
		ex = to_pixel(m_x);
		ey = to_pixel(m_y);
		assert (pos.x == ex && pos.y == ey) else begin
			$display("FAIL time %0t: pos %0d,%0d expected %0d,%0d", $time, pos.x, pos.y, ex, ey);
			$display("TESTS FAILED");
			$fatal(1, "position mismatch");
		end
		assert (dead_led == m_dead) else begin
			$display("FAIL time %0t: dead_led %0b expected %0b", $time, dead_led, m_dead);
			$display("TESTS FAILED");
			$fatal(1, "dead_led mismatch");
		end
	endtask

	task automatic check_start();
		assert (pos.x == 24 && pos.y == 24 && dead_led == 1'b0) else begin
			$display("FAIL time %0t: after reset pos %0d,%0d dead_led %0b", $time,
				pos.x, pos.y, dead_led);
			$display("TESTS FAILED");
			$fatal(1, "bad reset state");
		end
	endtask

	// one frame, pulse first and check right after it
	task automatic run_frame(input logic hz);
		for (int c = 0; c < frame_cycles; c++) begin
			@(negedge clk);
			start_of_frame = (c == 0);
			hazard         = hz && (c == 4);
			if (c == 1)
				check_outputs();
		end
	endtask

	// reset for two cycles inside one frame slot
	task automatic restart_frame();
		for (int c = 0; c < frame_cycles; c++) begin
			@(negedge clk);
			start_of_frame = 1'b0;
			hazard         = 1'b0;
			resetN         = (c >= 2);
			if (c == 2)
				check_start();
		end
	endtask

	initial begin
		resetN         = 1'b0;
		start_of_frame = 1'b0;
		keys           = '0;
		hazard         = 1'b0;
		rng            = 32'ha44b;
		hold           = 0;
		after_death    = 0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		resetN = 1'b1;
		check_start();
		for (int f = 0; f < n_frames; f++) begin
			if (after_death == 1) begin
				restart_frame();
				after_death = 0;
			end
			else begin
				if (hold == 0) begin
					rng  = xorshift32(rng);
					keys = pick_keys(rng);
					rng  = xorshift32(rng);
					hold = 1 + rng % 20;
				end
				hold--;
				rng        = xorshift32(rng);
				hit_hazard = (after_death == 0) && (rng % 300 == 0); // rare
				if (hit_hazard)
					after_death = 6;
				else if (after_death > 1)
					after_death--;
				run_frame(hit_hazard);
			end
		end
		$display("TESTS PASSED");
		$finish;
	end

	initial begin
		#(timeout_cycles * clk_period);
		$display("watchdog expired before all frames were run");
		$display("TESTS FAILED");
		$fatal(1, "timeout");
	end

endmodule

// ==== list.f ====
+incdir+tests
src/geom_pkg.sv
src/bumpy_pkg.sv
src/frame_edge_detect.sv
src/bumpy_fsm.sv
src/bumpy_move.sv
src/bumpy_top.sv
tests/bumpy_tb.sv
